// ==== verilog.f ====
verilog/relobi_pkg.sv
verilog/hsiao_ecc_pkg.sv
verilog/hsiao_ecc_enc.sv
verilog/hsiao_ecc_dec.sv
verilog/relobi_encoder.sv
verilog/relobi_decoder.sv
verilog/obi_sram.sv
verilog/relobi_mem_top.sv
verif/relobi_tb.sv

// ==== verif/relobi_tb.sv ====
// Self-checking testbench for the reliable OBI memory link.
// Runs clean traffic and injected link faults, compares read data with a
// reference memory model and checks the voter and ECC error flags.
`timescale 1ns/10ps
`default_nettype none

module relobi_tb;

  localparam int unsigned NumRand   = 32;
  localparam int unsigned NumFault  = 8;
  localparam int unsigned NumDouble = 4;
  localparam int unsigned NumVote   = 6;
  localparam int unsigned NumB2b    = 16;
  localparam int unsigned NumCheck  = hsiao_ecc_pkg::DataCodeWidth - relobi_pkg::DataWidth;
  localparam int unsigned NumXfers  = relobi_pkg::MemDepth + 2 * NumRand + 5 * NumFault +
                                      3 * NumDouble + 2 * NumVote + NumB2b;
  localparam int unsigned MaxCycles = 4 * NumXfers + 100;

  logic                       clk;
  logic                       arst_n;
  logic                       req;
  relobi_pkg::addr_t          addr;
  logic                       we;
  relobi_pkg::be_t            be;
  relobi_pkg::data_t          wdata;
  relobi_pkg::tmr_t           req_mask;
  hsiao_ecc_pkg::addr_code_t  addr_mask;
  hsiao_ecc_pkg::data_code_t  wdata_mask;
  hsiao_ecc_pkg::data_code_t  rdata_mask;
  logic                       gnt;
  logic                       rvalid;
  logic                       rsp_err;
  relobi_pkg::data_t          rdata;
  relobi_pkg::relerr_t        relerr;
  relobi_pkg::relerr_t        rsp_relerr;

  relobi_pkg::data_t          ref_mem [relobi_pkg::MemDepth];  // Reference memory
  logic                       exp_chk_q [$];                   // Read response to check
  relobi_pkg::data_t          exp_data_q [$];
  relobi_pkg::relerr_t        exp_rsp_q [$];
  integer                     seed = 71418;
  int unsigned                checks = 0;
  int unsigned                errors = 0;
  int unsigned                cycles = 0;
  logic                       xfer_prev;

  always #5 clk = ~clk;

  relobi_mem_top DUT (
    .clk_i              (clk),
    .arst_n_i           (arst_n),
    .req_i              (req),
    .addr_i             (addr),
    .we_i               (we),
    .be_i               (be),
    .wdata_i            (wdata),
    .fault_req_mask_i   (req_mask),
    .fault_addr_mask_i  (addr_mask),
    .fault_wdata_mask_i (wdata_mask),
    .fault_rdata_mask_i (rdata_mask),
    .gnt_o              (gnt),
    .rvalid_o           (rvalid),
    .rdata_o            (rdata),
    .rsp_err_o          (rsp_err),
    .relerr_o           (relerr),
    .rsp_relerr_o       (rsp_relerr)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic relobi_pkg::data_t merge_write(input relobi_pkg::data_t old_word,
      input relobi_pkg::data_t new_word, input relobi_pkg::be_t be_mask);
    relobi_pkg::data_t res;
    res = old_word;
    for (int b = 0; b < relobi_pkg::BeWidth; b++) begin
      if (be_mask[b]) res[8*b +: 8] = new_word[8*b +: 8];  // Byte lane taken from the write
    end
    return res;
  endfunction

  function automatic int unsigned word_idx(input relobi_pkg::addr_t a);
    return a[relobi_pkg::MemIdxWidth+1:2];
  endfunction

  // Random upper bits, word index in place, byte offset zero
  function automatic relobi_pkg::addr_t rand_addr(input int unsigned idx);
    relobi_pkg::addr_t a;
    a = {$random(seed)};
    a[relobi_pkg::MemIdxWidth+1:2] = idx[relobi_pkg::MemIdxWidth-1:0];
    a[1:0] = 2'b00;
    return a;
  endfunction

  task automatic check_flags(input relobi_pkg::relerr_t got, input relobi_pkg::relerr_t exp);
    checks++;
    assert (got === exp) else begin
      $display("Mismatch at %0t: request flags %b, expected %b", $time, got, exp);
      errors++;
    end
  endtask

  // Presents one request and returns in the grant cycle with req still high
  task automatic issue(input logic wr, input relobi_pkg::addr_t a, input relobi_pkg::be_t b,
      input relobi_pkg::data_t d, input relobi_pkg::tmr_t rq_m,
      input hsiao_ecc_pkg::addr_code_t a_m, input hsiao_ecc_pkg::data_code_t w_m,
      input hsiao_ecc_pkg::data_code_t r_m, input relobi_pkg::relerr_t exp_err,
      input relobi_pkg::relerr_t exp_rsp);
    @(posedge clk);
    req        <= 1'b1;
    addr       <= a;
    we         <= wr;
    be         <= b;
    wdata      <= d;
    req_mask   <= rq_m;
    addr_mask  <= a_m;
    wdata_mask <= w_m;
    rdata_mask <= r_m;                                   // Held into the response cycle
    @(negedge clk);
    while (!gnt) @(negedge clk);
    check_flags(relerr, exp_err);
    exp_chk_q.push_back(!wr);
    exp_data_q.push_back(ref_mem[word_idx(a)]);
    exp_rsp_q.push_back(exp_rsp);
    if (wr) ref_mem[word_idx(a)] = merge_write(ref_mem[word_idx(a)], d, b);
  endtask

  task automatic idle();
    @(posedge clk);
    req        <= 1'b0;
    req_mask   <= '0;
    addr_mask  <= '0;
    wdata_mask <= '0;
  endtask

  task automatic report(input string name, input int unsigned chk0, input int unsigned err0);
    repeat (3) @(negedge clk);                           // Let the last response land
    $display("%-20s %0d checks, %0d errors", name, checks - chk0, errors - err0);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response comparator
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin : compare_rsp
    logic                chk;
    relobi_pkg::data_t   exp_data;
    relobi_pkg::relerr_t exp_rsp;
    if (!arst_n) begin
      xfer_prev = 1'b0;
    end else begin
      checks++;
      assert (rvalid === xfer_prev) else begin
        $display("Response timing wrong at %0t: rvalid %b after transfer %b",
                 $time, rvalid, xfer_prev);
        errors++;
      end
      if (rvalid) begin
        checks++;
        assert (!gnt) else begin
          $display("Grant given at %0t while a response was due", $time);
          errors++;
        end
        checks++;
        assert (exp_chk_q.size() > 0) else begin
          $display("Response at %0t with no request outstanding", $time);
          errors++;
        end
        if (exp_chk_q.size() > 0) begin
          chk      = exp_chk_q.pop_front();
          exp_data = exp_data_q.pop_front();
          exp_rsp  = exp_rsp_q.pop_front();
          if (chk) begin
            checks += 3;
            assert (rdata === exp_data) else begin
              $display("Mismatch at %0t: rdata %h, expected %h", $time, rdata, exp_data);
              errors++;
            end
            assert (rsp_relerr === exp_rsp) else begin
              $display("Mismatch at %0t: response flags %b, expected %b",
                       $time, rsp_relerr, exp_rsp);
              errors++;
            end
            assert (rsp_err === exp_rsp[1]) else begin
              $display("Mismatch at %0t: rsp_err %b, expected %b", $time, rsp_err, exp_rsp[1]);
              errors++;
            end
          end
        end
      end
      xfer_prev = req & gnt;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout, the run did not finish within %0d cycles", MaxCycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    relobi_pkg::addr_t a;
    relobi_pkg::addr_t addr_list [NumRand];
    int unsigned       bit_a;
    int unsigned       bit_b;
    int unsigned       chk0;
    int unsigned       err0;
    clk        = 1'b0;
    arst_n     = 1'b0;
    req        = 1'b0;
    addr       = '0;
    we         = 1'b0;
    be         = '0;
    wdata      = '0;
    req_mask   = '0;
    addr_mask  = '0;
    wdata_mask = '0;
    rdata_mask = '0;
    xfer_prev  = 1'b0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < relobi_pkg::MemDepth; i++) begin   // Preload every word
      issue(1'b1, rand_addr(i), 4'hF, $random(seed), '0, '0, '0, '0, 2'b00, 2'b00);
      idle();
    end
    for (int i = 0; i < NumRand; i++) begin
      addr_list[i] = rand_addr({$random(seed)} % relobi_pkg::MemDepth);
      issue(1'b1, addr_list[i], $random(seed), $random(seed), '0, '0, '0, '0, 2'b00, 2'b00);
      idle();
    end
    for (int i = 0; i < NumRand; i++) begin
      issue(1'b0, addr_list[i], '0, '0, '0, '0, '0, '0, 2'b00, 2'b00);
      idle();
    end
    report("clean traffic", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < NumFault; i++) begin
      a     = rand_addr({$random(seed)} % relobi_pkg::MemDepth);
      bit_a = {$random(seed)} % hsiao_ecc_pkg::AddrCodeWidth;
      issue(1'b1, a, 4'hF, $random(seed), '0, hsiao_ecc_pkg::addr_code_t'(1) << bit_a,
            '0, '0, 2'b01, 2'b00);
      idle();
      issue(1'b0, a, '0, '0, '0, '0, '0, '0, 2'b00, 2'b00);
      idle();
      bit_a = {$random(seed)} % hsiao_ecc_pkg::DataCodeWidth;
      issue(1'b1, a, $random(seed), $random(seed), '0, '0,
            hsiao_ecc_pkg::data_code_t'(1) << bit_a, '0, 2'b01, 2'b00);
      idle();
      issue(1'b0, a, '0, '0, '0, '0, '0, '0, 2'b00, 2'b00);
      idle();
      bit_a = {$random(seed)} % hsiao_ecc_pkg::DataCodeWidth;
      issue(1'b0, a, '0, '0, '0, '0, '0, hsiao_ecc_pkg::data_code_t'(1) << bit_a,
            2'b00, 2'b01);
      idle();
    end
    report("single-bit faults", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < NumDouble; i++) begin
      a     = rand_addr({$random(seed)} % relobi_pkg::MemDepth);
      bit_a = {$random(seed)} % hsiao_ecc_pkg::DataCodeWidth;
      bit_b = (bit_a + 1 + {$random(seed)} % (hsiao_ecc_pkg::DataCodeWidth - 1)) %
              hsiao_ecc_pkg::DataCodeWidth;
      issue(1'b1, a, 4'hF, $random(seed), '0, '0,
            (hsiao_ecc_pkg::data_code_t'(1) << bit_a) | (hsiao_ecc_pkg::data_code_t'(1) << bit_b),
            '0, 2'b10, 2'b00);
      idle();
      issue(1'b1, a, 4'hF, $random(seed), '0, '0, '0, '0, 2'b00, 2'b00);  // Restore word
      idle();
      bit_a = {$random(seed)} % NumCheck;
      bit_b = (bit_a + 1 + {$random(seed)} % (NumCheck - 1)) % NumCheck;
      issue(1'b0, a, '0, '0, '0, '0, '0,
            hsiao_ecc_pkg::data_code_t'((1 << bit_a) | (1 << bit_b)) << relobi_pkg::DataWidth,
            2'b00, 2'b10);                                // Two check bits, data arrives intact
      idle();
    end
    report("double-bit faults", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < NumVote; i++) begin
      a = rand_addr({$random(seed)} % relobi_pkg::MemDepth);
      issue(1'b1, a, $random(seed), $random(seed), relobi_pkg::tmr_t'(1) << ({$random(seed)} % 3),
            '0, '0, '0, 2'b01, 2'b00);
      idle();
      issue(1'b0, a, '0, '0, relobi_pkg::tmr_t'(1) << ({$random(seed)} % 3),
            '0, '0, '0, 2'b01, 2'b00);
      idle();
    end
    report("voter faults", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < NumB2b; i++) begin                 // req held high between transfers
      issue(i[0], rand_addr(i % 4), $random(seed), $random(seed), '0, '0, '0, '0, 2'b00, 2'b00);
    end
    idle();
    report("back-to-back timing", chk0, err0);

    checks++;
    assert (exp_chk_q.size() == 0) else begin
      $display("%0d responses never arrived", exp_chk_q.size());
      errors++;
    end
    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/relobi_mem_top.sv ====
// Reliable OBI link from one manager to a word SRAM.
// The fault masks are XORed onto the protected link for error testing.
`timescale 1ns/10ps
`default_nettype none

module relobi_mem_top (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  input  wire logic                       req_i,
  input  wire relobi_pkg::addr_t          addr_i,
  input  wire logic                       we_i,
  input  wire relobi_pkg::be_t            be_i,
  input  wire relobi_pkg::data_t          wdata_i,
  input  wire relobi_pkg::tmr_t           fault_req_mask_i,
  input  wire hsiao_ecc_pkg::addr_code_t  fault_addr_mask_i,
  input  wire hsiao_ecc_pkg::data_code_t  fault_wdata_mask_i,
  input  wire hsiao_ecc_pkg::data_code_t  fault_rdata_mask_i,
  output logic                            gnt_o,
  output logic                            rvalid_o,
  output relobi_pkg::data_t               rdata_o,
  output logic                            rsp_err_o,
  output relobi_pkg::relerr_t             relerr_o,
  output relobi_pkg::relerr_t             rsp_relerr_o
);

  relobi_pkg::tmr_t            rel_req;
  hsiao_ecc_pkg::addr_code_t   rel_addr;
  hsiao_ecc_pkg::data_code_t   rel_wdata;
  hsiao_ecc_pkg::other_code_t  rel_other;
  relobi_pkg::tmr_t            rel_gnt;
  relobi_pkg::tmr_t            rel_rvalid;
  hsiao_ecc_pkg::data_code_t   rel_rdata;
  relobi_pkg::tmr_t            rel_req_flt;      // After fault injection
  hsiao_ecc_pkg::addr_code_t   rel_addr_flt;
  hsiao_ecc_pkg::data_code_t   rel_wdata_flt;
  hsiao_ecc_pkg::data_code_t   rel_rdata_flt;
  logic                        mem_req;
  relobi_pkg::addr_t           mem_addr;
  logic                        mem_we;
  relobi_pkg::be_t             mem_be;
  relobi_pkg::data_t           mem_wdata;
  logic                        mem_gnt;
  logic                        mem_rvalid;
  relobi_pkg::data_t           mem_rdata;

  relobi_encoder i_encoder (
    .req_i        (req_i),
    .addr_i       (addr_i),
    .we_i         (we_i),
    .be_i         (be_i),
    .wdata_i      (wdata_i),
    .gnt_o        (gnt_o),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o),
    .rsp_err_o    (rsp_err_o),
    .rel_req_o    (rel_req),
    .rel_addr_o   (rel_addr),
    .rel_wdata_o  (rel_wdata),
    .rel_other_o  (rel_other),
    .rel_gnt_i    (rel_gnt),
    .rel_rvalid_i (rel_rvalid),
    .rel_rdata_i  (rel_rdata_flt),
    .rsp_relerr_o (rsp_relerr_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fault injection on the link
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rel_req_flt   = rel_req   ^ fault_req_mask_i;
  assign rel_addr_flt  = rel_addr  ^ fault_addr_mask_i;
  assign rel_wdata_flt = rel_wdata ^ fault_wdata_mask_i;
  assign rel_rdata_flt = rel_rdata ^ fault_rdata_mask_i;

  relobi_decoder i_decoder (
    .rel_req_i    (rel_req_flt),
    .rel_addr_i   (rel_addr_flt),
    .rel_wdata_i  (rel_wdata_flt),
    .rel_other_i  (rel_other),
    .rel_gnt_o    (rel_gnt),
    .rel_rvalid_o (rel_rvalid),
    .rel_rdata_o  (rel_rdata),
    .mem_req_o    (mem_req),
    .mem_addr_o   (mem_addr),
    .mem_we_o     (mem_we),
    .mem_be_o     (mem_be),
    .mem_wdata_o  (mem_wdata),
    .mem_gnt_i    (mem_gnt),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata),
    .relerr_o     (relerr_o)
  );

  obi_sram i_sram (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (mem_req),
    .addr_i   (mem_addr),
    .we_i     (mem_we),
    .be_i     (mem_be),
    .wdata_i  (mem_wdata),
    .gnt_o    (mem_gnt),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== verilog/obi_sram.sv ====
// Single-port word SRAM with a plain OBI subordinate port.
// Grants whenever no response is due and answers one cycle later.
// A write returns the old word, which the manager ignores.
`timescale 1ns/10ps
`default_nettype none

module obi_sram (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire logic              req_i,
  input  wire relobi_pkg::addr_t addr_i,
  input  wire logic              we_i,
  input  wire relobi_pkg::be_t   be_i,
  input  wire relobi_pkg::data_t wdata_i,
  output logic                   gnt_o,
  output logic                   rvalid_o,
  output relobi_pkg::data_t      rdata_o
);

  relobi_pkg::data_t                    mem [relobi_pkg::MemDepth];
  logic [relobi_pkg::MemIdxWidth-1:0]   idx;
  logic                                 xfer;
  logic                                 rvalid_q;
  relobi_pkg::data_t                    rdata_q;

  assign idx   = addr_i[relobi_pkg::MemIdxWidth+1:2];  // Word address
  assign gnt_o = req_i & ~rvalid_q;                    // Busy while answering
  assign xfer  = req_i & gnt_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= xfer;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      rdata_q <= mem[idx];                             // Old word on write
      if (we_i) begin
        for (int unsigned b = 0; b < relobi_pkg::BeWidth; b++) begin
          if (be_i[b]) mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

`default_nettype wire

// ==== verilog/relobi_decoder.sv ====
// Subordinate-side reliable OBI converter.
// Votes the request strobe, corrects the protected request fields and
// re-encodes the read data. relerr_o reports any request-side fault.
`timescale 1ns/10ps
`default_nettype none

module relobi_decoder (
  // Reliable link
  input  wire relobi_pkg::tmr_t            rel_req_i,
  input  wire hsiao_ecc_pkg::addr_code_t   rel_addr_i,
  input  wire hsiao_ecc_pkg::data_code_t   rel_wdata_i,
  input  wire hsiao_ecc_pkg::other_code_t  rel_other_i,
  output relobi_pkg::tmr_t                 rel_gnt_o,
  output relobi_pkg::tmr_t                 rel_rvalid_o,
  output hsiao_ecc_pkg::data_code_t        rel_rdata_o,
  // Plain OBI towards the memory
  output logic                             mem_req_o,
  output relobi_pkg::addr_t                mem_addr_o,
  output logic                             mem_we_o,
  output relobi_pkg::be_t                  mem_be_o,
  output relobi_pkg::data_t                mem_wdata_o,
  input  wire logic                        mem_gnt_i,
  input  wire logic                        mem_rvalid_i,
  input  wire relobi_pkg::data_t           mem_rdata_i,
  output relobi_pkg::relerr_t              relerr_o
);

  logic                req_vote_err;
  relobi_pkg::other_t  other;
  relobi_pkg::relerr_t addr_err;
  relobi_pkg::relerr_t wdata_err;
  relobi_pkg::relerr_t other_err;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign mem_req_o    = relobi_pkg::tmr_majority(rel_req_i);
  assign req_vote_err = relobi_pkg::tmr_mismatch(rel_req_i);

  hsiao_ecc_dec #(
    .DataWidth (relobi_pkg::AddrWidth)
  ) i_addr_dec (
    .code_i     (rel_addr_i),
    .data_o     (mem_addr_o),
    .syndrome_o (),
    .err_o      (addr_err)
  );

  hsiao_ecc_dec #(
    .DataWidth (relobi_pkg::DataWidth)
  ) i_wdata_dec (
    .code_i     (rel_wdata_i),
    .data_o     (mem_wdata_o),
    .syndrome_o (),
    .err_o      (wdata_err)
  );

  hsiao_ecc_dec #(
    .DataWidth (relobi_pkg::OtherWidth)
  ) i_other_dec (
    .code_i     (rel_other_i),
    .data_o     (other),
    .syndrome_o (),
    .err_o      (other_err)
  );

  assign mem_we_o = other[relobi_pkg::BeWidth];
  assign mem_be_o = other[relobi_pkg::BeWidth-1:0];

  assign relerr_o[0] = req_vote_err | addr_err[0] | wdata_err[0] | other_err[0];
  assign relerr_o[1] = addr_err[1] | wdata_err[1] | other_err[1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rel_gnt_o    = {3{mem_gnt_i}};
  assign rel_rvalid_o = {3{mem_rvalid_i}};

  hsiao_ecc_enc #(
    .DataWidth (relobi_pkg::DataWidth)
  ) i_rdata_enc (
    .data_i (mem_rdata_i),
    .code_o (rel_rdata_o)
  );

endmodule

`default_nettype wire

// ==== verilog/relobi_encoder.sv ====
// Manager-side reliable OBI converter.
// Triplicates the request strobe and ECC-protects the request fields,
// then votes and corrects the response coming back over the link.
`timescale 1ns/10ps
`default_nettype none

module relobi_encoder (
  // Plain OBI from the manager
  input  wire logic                       req_i,
  input  wire relobi_pkg::addr_t          addr_i,
  input  wire logic                       we_i,
  input  wire relobi_pkg::be_t            be_i,
  input  wire relobi_pkg::data_t          wdata_i,
  output logic                            gnt_o,
  output logic                            rvalid_o,
  output relobi_pkg::data_t               rdata_o,
  output logic                            rsp_err_o,
  // Reliable link
  output relobi_pkg::tmr_t                rel_req_o,
  output hsiao_ecc_pkg::addr_code_t       rel_addr_o,
  output hsiao_ecc_pkg::data_code_t       rel_wdata_o,
  output hsiao_ecc_pkg::other_code_t      rel_other_o,
  input  wire relobi_pkg::tmr_t           rel_gnt_i,
  input  wire relobi_pkg::tmr_t           rel_rvalid_i,
  input  wire hsiao_ecc_pkg::data_code_t  rel_rdata_i,
  output relobi_pkg::relerr_t             rsp_relerr_o
);

  relobi_pkg::other_t  other;
  relobi_pkg::relerr_t rdata_err;
  logic                gnt_vote_err;
  logic                rvalid_vote_err;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Request path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rel_req_o = {3{req_i}};
  assign other     = {we_i, be_i};

  hsiao_ecc_enc #(
    .DataWidth (relobi_pkg::AddrWidth)
  ) i_addr_enc (
    .data_i (addr_i),
    .code_o (rel_addr_o)
  );

  hsiao_ecc_enc #(
    .DataWidth (relobi_pkg::DataWidth)
  ) i_wdata_enc (
    .data_i (wdata_i),
    .code_o (rel_wdata_o)
  );

  hsiao_ecc_enc #(
    .DataWidth (relobi_pkg::OtherWidth)
  ) i_other_enc (
    .data_i (other),
    .code_o (rel_other_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Response path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign gnt_o           = relobi_pkg::tmr_majority(rel_gnt_i);
  assign gnt_vote_err    = relobi_pkg::tmr_mismatch(rel_gnt_i);
  assign rvalid_o        = relobi_pkg::tmr_majority(rel_rvalid_i);
  assign rvalid_vote_err = relobi_pkg::tmr_mismatch(rel_rvalid_i);

  hsiao_ecc_dec #(
    .DataWidth (relobi_pkg::DataWidth)
  ) i_rdata_dec (
    .code_i     (rel_rdata_i),
    .data_o     (rdata_o),
    .syndrome_o (),
    .err_o      (rdata_err)
  );

  // Read data only counts while a response is on the link
  assign rsp_relerr_o[0] = gnt_vote_err | rvalid_vote_err | (rvalid_o & rdata_err[0]);
  assign rsp_relerr_o[1] = rvalid_o & rdata_err[1];
  assign rsp_err_o       = rsp_relerr_o[1];

endmodule

`default_nettype wire

// ==== verilog/hsiao_ecc_dec.sv ====
// Hsiao SEC-DED syndrome decoder.
// Corrects one flipped bit anywhere in the code word and flags two.
// err_o[0] marks a corrected error, err_o[1] an uncorrectable one.
`timescale 1ns/10ps
`default_nettype none

module hsiao_ecc_dec #(
  parameter  int unsigned DataWidth  = 32,
  localparam int unsigned CheckWidth = hsiao_ecc_pkg::check_width(DataWidth)
) (
  input  wire logic [DataWidth+CheckWidth-1:0] code_i,
  output logic      [DataWidth-1:0]            data_o,
  output hsiao_ecc_pkg::syndrome_t             syndrome_o,
  output relobi_pkg::relerr_t                  err_o
);

  logic [DataWidth-1:0]     data_in;
  logic [CheckWidth-1:0]    check_in;
  hsiao_ecc_pkg::syndrome_t syndrome;
  logic                     matched;

  assign data_in  = code_i[DataWidth-1:0];
  assign check_in = code_i[DataWidth+CheckWidth-1:DataWidth];

  // Recompute the check bits and compare against the received ones
  always_comb begin
    syndrome = hsiao_ecc_pkg::syndrome_t'(check_in);
    for (int unsigned i = 0; i < DataWidth; i++) begin
      if (data_in[i]) begin
        syndrome = syndrome ^ hsiao_ecc_pkg::col_sel(CheckWidth, i);
      end
    end
  end

  assign syndrome_o = syndrome;

  always_comb begin
    data_o  = data_in;
    err_o   = '0;
    matched = 1'b0;
    if (syndrome != '0) begin
      if ($countones(syndrome) % 2 == 1) begin
        // Weight one is a flipped check bit, the data is already right
        if ($countones(syndrome) == 1) matched = 1'b1;
        for (int unsigned i = 0; i < DataWidth; i++) begin
          if (syndrome == hsiao_ecc_pkg::col_sel(CheckWidth, i)) begin
            data_o[i] = ~data_in[i];
            matched   = 1'b1;
          end
        end
        err_o[0] = matched;
        err_o[1] = ~matched;        // Odd weight but no column, three or more flips
      end else begin
        err_o[1] = 1'b1;            // Even weight, double error
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hsiao_ecc_enc.sv ====
// Hsiao SEC-DED check-bit generator.
// The code word carries the check bits above the unchanged data bits.
`timescale 1ns/10ps
`default_nettype none

module hsiao_ecc_enc #(
  parameter  int unsigned DataWidth  = 32,
  localparam int unsigned CheckWidth = hsiao_ecc_pkg::check_width(DataWidth)
) (
  input  wire logic [DataWidth-1:0]            data_i,
  output logic      [DataWidth+CheckWidth-1:0] code_o
);

  hsiao_ecc_pkg::syndrome_t check;

  // Each set data bit folds its column into the check bits
  always_comb begin
    check = '0;
    for (int unsigned i = 0; i < DataWidth; i++) begin
      if (data_i[i]) begin
        check = check ^ hsiao_ecc_pkg::col_sel(CheckWidth, i);
      end
    end
  end

  assign code_o = {check[CheckWidth-1:0], data_i};

endmodule

`default_nettype wire

// ==== verilog/hsiao_ecc_pkg.sv ====
// Hsiao SEC-DED code geometry shared by the check-bit generator and the
// syndrome decoder. Columns are odd-weight vectors of weight three or more.
`default_nettype none

package hsiao_ecc_pkg;

  localparam int unsigned MaxCheckWidth = 8;  // Enough for 120 data bits

  typedef logic [MaxCheckWidth-1:0] syndrome_t;

  // Smallest r with 2^(r-1) >= k + r
  function automatic int unsigned check_width(input int unsigned k);
    int unsigned r;
    r = 2;
    while ((2 ** (r - 1)) < (k + r)) begin
      r++;
    end
    return r;
  endfunction

  // Column idx of the parity matrix for r check bits
  function automatic syndrome_t col_sel(input int unsigned r, input int unsigned idx);
    int unsigned found;
    syndrome_t   col;
    found = 0;
    col   = '0;
    for (int unsigned v = 0; v < (1 << r); v++) begin
      if (($countones(v) >= 3) && ($countones(v) % 2 == 1)) begin
        if (found == idx) col = syndrome_t'(v);
        found++;
      end
    end
    return col;
  endfunction

  localparam int unsigned AddrCodeWidth  =
    relobi_pkg::AddrWidth + check_width(relobi_pkg::AddrWidth);   // 39
  localparam int unsigned DataCodeWidth  =
    relobi_pkg::DataWidth + check_width(relobi_pkg::DataWidth);   // 39
  localparam int unsigned OtherCodeWidth =
    relobi_pkg::OtherWidth + check_width(relobi_pkg::OtherWidth); // 10

  typedef logic [AddrCodeWidth-1:0]  addr_code_t;
  typedef logic [DataCodeWidth-1:0]  data_code_t;
  typedef logic [OtherCodeWidth-1:0] other_code_t;

endpackage

`default_nettype wire

// ==== verilog/relobi_pkg.sv ====
// Bus widths and vector types for the plain and the reliable OBI link.
// Also holds the small TMR helpers shared by both link converters.
`default_nettype none

package relobi_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Bus geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned AddrWidth   = 32;             // Byte address
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned BeWidth     = DataWidth / 8;
  localparam int unsigned OtherWidth  = BeWidth + 1;    // we above be
  localparam int unsigned MemDepth    = 256;            // Words
  localparam int unsigned MemIdxWidth = $clog2(MemDepth);

  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [DataWidth-1:0]  data_t;
  typedef logic [BeWidth-1:0]    be_t;
  typedef logic [OtherWidth-1:0] other_t;
  typedef logic [2:0]            tmr_t;     // Triplicated strobe
  typedef logic [1:0]            relerr_t;  // [0] corrected, [1] fatal

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Triplicated strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic tmr_majority(input tmr_t lanes);
    return (lanes[0] & lanes[1]) | (lanes[0] & lanes[2]) | (lanes[1] & lanes[2]);
  endfunction

  // High when the lanes do not all agree
  function automatic logic tmr_mismatch(input tmr_t lanes);
    return (|lanes) & ~(&lanes);
  endfunction

endpackage

`default_nettype wire
